// ==== include/fetch_defs.svh ====
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Boot address
`define RESET_VECTOR 32'h0000_0000

// addi x0, x0, 0
`define INSTR_NOP 32'h0000_0013

// One word per line
`define ICACHE_LINES 8

// 64 words, so 256 bytes of program space
`define IMEM_WORDS 64

// Cycles from mem_req to mem_valid
`define IMEM_LATENCY 2

`endif

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb -f verilog.f -o fetch_sim
./obj_dir/fetch_sim 2>&1 | tee sim.log
if grep -q "all tests passed" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

// ==== src/fetch_pkg.sv ====
package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [5:0]  imem_addr_t;

    typedef enum logic [1:0] {
        CMD_NONE      = 2'd0,
        CMD_EXECUTE   = 2'd1,
        CMD_FLUSH_ALL = 2'd2
    } cache_cmd_e;

    typedef enum logic [2:0] {
        RESP_IDLE        = 3'd0,
        RESP_WAIT        = 3'd1,
        RESP_DONE        = 3'd2,
        RESP_MISALIGNED  = 3'd3,
        RESP_ACCESSFAULT = 3'd4
    } cache_resp_e;

    // mcause codes, interrupt flag travels separately
    typedef enum logic [3:0] {
        CAUSE_INSTR_MISALIGNED   = 4'd0,
        CAUSE_INSTR_ACCESS_FAULT = 4'd1,
        CAUSE_TIMER_IRQ          = 4'd7,
        CAUSE_EXT_IRQ            = 4'd11
    } exc_cause_e;

    typedef struct packed {
        word_t      instr;
        addr_t      pc;
        logic       exc_start;
        exc_cause_e cause;
        logic       interrupt;
    } f2e_t;

    typedef struct packed {
        logic  ready;
        logic  exc_start;
        logic  flush;
        logic  branch_taken;
        addr_t branch_target;
    } e2f_t;

endpackage

// ==== src/fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top import fetch_pkg::*; (
    input  logic       clk,
    input  logic       reseted,
    input  addr_t      mtvec,
    input  logic       irq_timer,
    input  logic       irq_exti,
    input  e2f_t       e2f,
    input  logic       prog_we,
    input  imem_addr_t prog_addr,
    input  word_t      prog_data,
    output f2e_t       f2e
);

    cache_cmd_e  c_cmd;
    addr_t       c_address;
    cache_resp_e c_response;
    word_t       c_load_data;
    logic        c_reset_done;
    logic        mem_req;
    imem_addr_t  mem_addr;
    logic        mem_valid;
    word_t       mem_data;

    fetch_unit fetch_unit_inst (
        .clk          (clk),
        .reseted      (reseted),
        .mtvec        (mtvec),
        .irq_timer    (irq_timer),
        .irq_exti     (irq_exti),
        .e2f          (e2f),
        .c_response   (c_response),
        .c_reset_done (c_reset_done),
        .c_load_data  (c_load_data),
        .c_cmd        (c_cmd),
        .c_address    (c_address),
        .f2e          (f2e)
    );

    icache icache_inst (
        .clk          (clk),
        .reseted      (reseted),
        .c_cmd        (c_cmd),
        .c_address    (c_address),
        .c_response   (c_response),
        .c_load_data  (c_load_data),
        .c_reset_done (c_reset_done),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_valid    (mem_valid),
        .mem_data     (mem_data)
    );

    instr_mem instr_mem_inst (
        .clk       (clk),
        .reseted   (reseted),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_valid (mem_valid),
        .mem_data  (mem_data)
    );

endmodule

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ns

`include "fetch_defs.svh"

module fetch_unit import fetch_pkg::*; (
    input  logic        clk,
    input  logic        reseted,
    input  addr_t       mtvec,
    input  logic        irq_timer,
    input  logic        irq_exti,
    input  e2f_t        e2f,
    input  cache_resp_e c_response,
    input  logic        c_reset_done,
    input  word_t       c_load_data,
    output cache_cmd_e  c_cmd,
    output addr_t       c_address,
    output f2e_t        f2e
);

    addr_t      pc;
    addr_t      next_pc;
    word_t      saved_instr;
    logic       booting;
    logic       flushing;
    logic       can_issue;
    logic       resp_wait;
    logic       fault;
    logic       exc_req;
    logic       redirect_taken;
    exc_cause_e cause;

    assign can_issue = c_reset_done && e2f.ready;
    assign resp_wait = (c_response == RESP_WAIT);
    assign fault = (c_response == RESP_MISALIGNED) || (c_response == RESP_ACCESSFAULT);
    assign exc_req = fault || irq_timer || irq_exti || e2f.exc_start;

    // An EXECUTE that actually moves to next_pc
    assign redirect_taken = can_issue && !booting && !resp_wait && !e2f.flush;

    // Faults first, then external, then timer
    always_comb begin
        cause = CAUSE_INSTR_MISALIGNED;
        if (c_response == RESP_MISALIGNED) begin
            cause = CAUSE_INSTR_MISALIGNED;
        end else if (c_response == RESP_ACCESSFAULT) begin
            cause = CAUSE_INSTR_ACCESS_FAULT;
        end else if (irq_exti) begin
            cause = CAUSE_EXT_IRQ;
        end else if (irq_timer) begin
            cause = CAUSE_TIMER_IRQ;
        end
    end

    always_comb begin
        if (booting) begin
            next_pc = `RESET_VECTOR;
        end else if (exc_req) begin
            next_pc = mtvec;
        end else if (e2f.branch_taken) begin
            next_pc = e2f.branch_target;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    // Same address is repeated while the line fills
    always_comb begin
        c_cmd = CMD_NONE;
        c_address = resp_wait ? pc : next_pc;
        if (can_issue) begin
            if (e2f.flush && !booting && !resp_wait) begin
                c_cmd = CMD_FLUSH_ALL;
            end else begin
                c_cmd = CMD_EXECUTE;
            end
        end
    end

    always_comb begin
        f2e.instr = `INSTR_NOP;
        f2e.pc = '0;
        f2e.exc_start = redirect_taken && exc_req;
        f2e.cause = cause;
        f2e.interrupt = f2e.exc_start && !fault && (irq_timer || irq_exti);
        if (c_reset_done && !booting) begin
            f2e.pc = pc;
            if (c_response == RESP_DONE && !flushing) begin
                f2e.instr = c_load_data;
            end else if (c_response == RESP_IDLE || flushing) begin
                f2e.instr = saved_instr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reseted) begin
            booting <= 1'b1;
            flushing <= 1'b0;
            pc <= `RESET_VECTOR;
        end else if (c_cmd == CMD_EXECUTE) begin
            pc <= c_address;
            booting <= 1'b0;
            flushing <= 1'b0;
        end else if (c_cmd == CMD_FLUSH_ALL) begin
            flushing <= 1'b1;
        end
    end

    // Kept for replay on stall or flush
    always_ff @(posedge clk) begin
        if (c_response == RESP_DONE && !flushing) begin
            saved_instr <= c_load_data;
        end
    end

endmodule

// ==== src/icache.sv ====
`timescale 1ns/1ns

`include "fetch_defs.svh"

module icache import fetch_pkg::*; (
    input  logic        clk,
    input  logic        reseted,
    input  cache_cmd_e  c_cmd,
    input  addr_t       c_address,
    output cache_resp_e c_response,
    output word_t       c_load_data,
    output logic        c_reset_done,
    output logic        mem_req,
    output imem_addr_t  mem_addr,
    input  logic        mem_valid,
    input  word_t       mem_data
);

    localparam int INDEX_W = $clog2(`ICACHE_LINES);
    localparam int TAG_W = 32 - INDEX_W - 2;
    localparam int MEM_AW = $bits(imem_addr_t);
    localparam addr_t IMEM_BYTES = addr_t'(`IMEM_WORDS * 4);

    typedef enum logic [1:0] {
        CLEARING,
        READY,
        FILLING
    } state_e;

    state_e                   state;
    logic [INDEX_W-1:0]       clear_idx;
    logic [`ICACHE_LINES-1:0] line_valid;
    logic [TAG_W-1:0]         line_tag [`ICACHE_LINES];
    word_t                    line_data [`ICACHE_LINES];
    logic [INDEX_W-1:0]       fill_idx;
    logic [TAG_W-1:0]         fill_tag;
    logic [INDEX_W-1:0]       req_idx;
    logic [TAG_W-1:0]         req_tag;
    logic                     hit;

    assign req_idx = c_address[INDEX_W+1:2];
    assign req_tag = c_address[31:INDEX_W+2];
    assign hit = line_valid[req_idx] && (line_tag[req_idx] == req_tag);
    assign c_reset_done = (state != CLEARING);

    always_ff @(posedge clk) begin
        if (reseted) begin
            state <= CLEARING;
            clear_idx <= '0;
            c_response <= RESP_IDLE;
            mem_req <= 1'b0;
        end else begin
            mem_req <= 1'b0;
            case (state)
                CLEARING: begin
                    clear_idx <= clear_idx + 1'b1;
                    if (clear_idx == INDEX_W'(`ICACHE_LINES - 1)) begin
                        state <= READY;
                    end
                end
                READY: begin
                    c_response <= RESP_IDLE;
                    if (c_cmd == CMD_EXECUTE) begin
                        if (c_address[1:0] != 2'b00) begin
                            c_response <= RESP_MISALIGNED;
                        end else if (c_address >= IMEM_BYTES) begin
                            c_response <= RESP_ACCESSFAULT;
                        end else if (hit) begin
                            c_response <= RESP_DONE;
                        end else begin
                            c_response <= RESP_WAIT;
                            mem_req <= 1'b1;
                            state <= FILLING;
                        end
                    end
                end
                FILLING: begin
                    // Commands are ignored until the word is back
                    if (mem_valid) begin
                        c_response <= RESP_DONE;
                        state <= READY;
                    end
                end
                default: state <= CLEARING;
            endcase
        end
    end

    // One line per cycle during the sweep
    always_ff @(posedge clk) begin
        if (state == CLEARING) begin
            line_valid[clear_idx] <= 1'b0;
        end else if (state == READY && c_cmd == CMD_FLUSH_ALL) begin
            line_valid <= '0;
        end else if (state == FILLING && mem_valid) begin
            line_valid[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == READY && c_cmd == CMD_EXECUTE) begin
            fill_idx <= req_idx;
            fill_tag <= req_tag;
            mem_addr <= c_address[MEM_AW+1:2];
            c_load_data <= line_data[req_idx];
        end
        if (state == FILLING && mem_valid) begin
            line_tag[fill_idx] <= fill_tag;
            line_data[fill_idx] <= mem_data;
            c_load_data <= mem_data;
        end
    end

endmodule

// ==== src/instr_mem.sv ====
`timescale 1ns/1ns

`include "fetch_defs.svh"

module instr_mem import fetch_pkg::*; (
    input  logic       clk,
    input  logic       reseted,
    input  logic       prog_we,
    input  imem_addr_t prog_addr,
    input  word_t      prog_data,
    input  logic       mem_req,
    input  imem_addr_t mem_addr,
    output logic       mem_valid,
    output word_t      mem_data
);

    word_t                    mem [`IMEM_WORDS];
    logic [`IMEM_LATENCY-1:0] valid_pipe;
    word_t                    data_pipe [`IMEM_LATENCY];

    // Program load port
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reseted) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= (valid_pipe << 1) | `IMEM_LATENCY'(mem_req);
        end
    end

    always_ff @(posedge clk) begin
        if (mem_req) begin
            data_pipe[0] <= mem[mem_addr];
        end
        for (int i = 1; i < `IMEM_LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign mem_valid = valid_pipe[`IMEM_LATENCY-1];
    assign mem_data = data_pipe[`IMEM_LATENCY-1];

endmodule

// ==== test/fetch_chk.sv ====
`timescale 1ns/1ns

`include "fetch_defs.svh"

module fetch_chk import fetch_pkg::*; (
    input logic        clk,
    input logic        reseted,
    input logic        mem_req,
    input logic        mem_valid,
    input cache_resp_e c_response,
    input logic        c_reset_done
);

    logic pending;

    // Set from the cycle after a request until the word is back
    always_ff @(posedge clk) begin
        if (reseted) begin
            pending <= 1'b0;
        end else if (mem_req) begin
            pending <= 1'b1;
        end else if (mem_valid) begin
            pending <= 1'b0;
        end
    end

    latency_req: assert property (@(posedge clk) disable iff (reseted)
        mem_req |-> ##(`IMEM_LATENCY) mem_valid)
        else $error("mem_valid missing after mem_req");

    latency_valid: assert property (@(posedge clk) disable iff (reseted)
        mem_valid |-> $past(mem_req, `IMEM_LATENCY))
        else $error("mem_valid without matching mem_req");

    single_req: assert property (@(posedge clk) disable iff (reseted)
        mem_req |-> !pending)
        else $error("mem_req while a fill is outstanding");

    idle_in_sweep: assert property (@(posedge clk) disable iff (reseted)
        !c_reset_done |-> c_response == RESP_IDLE)
        else $error("cache answered during reset sweep");

endmodule

bind icache fetch_chk fetch_chk_inst (
    .clk          (clk),
    .reseted      (reseted),
    .mem_req      (mem_req),
    .mem_valid    (mem_valid),
    .c_response   (c_response),
    .c_reset_done (c_reset_done)
);

// ==== test/fetch_golden.txt ====
// Header: program word count, record count, mtvec
// Then program words, then one record per cycle:
// irq_timer irq_exti ready exc_start flush br_taken br_target | check instr pc exc cause intr
8 2c 00000010
00100093 00200113 00308193 00418213 30200073 0000006f 00a00293 fe5ff0ef
0 0 1 0 0 0 00000000 1 00000013 00000000 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000000 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000000 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000000 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000000 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000000 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000000 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000000 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000000 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000000 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000000 0 0 0
0 0 1 0 0 0 00000000 1 00100093 00000000 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000004 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000004 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000004 0 0 0
0 0 1 0 0 0 00000000 1 00200113 00000004 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000008 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000008 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000008 0 0 0
0 0 1 0 0 1 00000000 1 00308193 00000008 0 0 0
0 0 1 0 0 0 00000000 1 00100093 00000000 0 0 0
0 0 1 0 0 0 00000000 1 00200113 00000004 0 0 0
0 0 0 0 0 0 00000000 1 00308193 00000008 0 0 0
0 0 0 0 0 0 00000000 1 00308193 00000008 0 0 0
0 0 0 0 0 0 00000000 1 00308193 00000008 0 0 0
0 0 1 0 0 0 00000000 1 00308193 00000008 0 0 0
0 0 1 0 0 0 00000000 1 00000013 0000000c 0 0 0
0 0 1 0 0 0 00000000 1 00000013 0000000c 0 0 0
0 0 1 0 0 0 00000000 1 00000013 0000000c 0 0 0
1 0 1 0 0 0 00000000 1 00418213 0000000c 1 7 1
0 0 1 0 0 0 00000000 1 00000013 00000010 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000010 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000010 0 0 0
1 1 1 0 0 0 00000000 1 30200073 00000010 1 b 1
0 0 1 0 0 1 00000006 1 30200073 00000010 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000006 1 0 0
0 0 1 0 0 1 00000100 1 30200073 00000010 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000100 1 1 0
0 0 1 0 1 0 00000000 1 30200073 00000010 0 0 0
0 0 1 0 0 1 00000000 1 30200073 00000010 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000000 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000000 0 0 0
0 0 1 0 0 0 00000000 1 00000013 00000000 0 0 0
0 0 1 0 0 0 00000000 1 00100093 00000000 0 0 0

// ==== test/fetch_tb.sv ====
`timescale 1ns/1ns

`include "fetch_defs.svh"

module fetch_tb import fetch_pkg::*; ();

    localparam int REC_FIELDS = 13;

    logic       clk;
    logic       reseted;
    addr_t      mtvec;
    logic       irq_timer;
    logic       irq_exti;
    e2f_t       e2f;
    logic       prog_we;
    imem_addr_t prog_addr;
    word_t      prog_data;
    f2e_t       f2e;

    logic [31:0] golden [0:1023];
    int          prog_count;
    int          rec_count;

    fetch_top fetch_top_inst (
        .clk       (clk),
        .reseted   (reseted),
        .mtvec     (mtvec),
        .irq_timer (irq_timer),
        .irq_exti  (irq_exti),
        .e2f       (e2f),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .f2e       (f2e)
    );

    always #50 clk = ~clk;

    task automatic stop_on_error();
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_f2e(input int base);
        word_t exp_instr;
        addr_t exp_pc;
        logic  exp_exc;
        logic  exp_int;
        exp_instr = golden[base + 8];
        exp_pc = golden[base + 9];
        exp_exc = golden[base + 10][0];
        exp_int = golden[base + 12][0];
        assert (f2e.instr == exp_instr) else begin
            $display("mismatch at %0t: instr %h, expected %h", $time, f2e.instr, exp_instr);
            stop_on_error();
        end
        assert (f2e.pc == exp_pc) else begin
            $display("mismatch at %0t: pc %h, expected %h", $time, f2e.pc, exp_pc);
            stop_on_error();
        end
        assert (f2e.exc_start == exp_exc) else begin
            $display("mismatch at %0t: exc_start %b, expected %b", $time, f2e.exc_start, exp_exc);
            stop_on_error();
        end
        assert (f2e.interrupt == exp_int) else begin
            $display("mismatch at %0t: interrupt %b, expected %b", $time, f2e.interrupt, exp_int);
            stop_on_error();
        end
        // Cause only means something with exc_start
        if (exp_exc) begin
            assert (f2e.cause == golden[base + 11][3:0]) else begin
                $display("mismatch at %0t: cause %0d, expected %0d", $time, f2e.cause,
                         golden[base + 11][3:0]);
                stop_on_error();
            end
        end
    endtask

    initial begin
        int i;
        int base;
        clk = 1'b0;
        reseted = 1'b1;
        irq_timer = 1'b0;
        irq_exti = 1'b0;
        e2f = '0;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        $readmemh("test/fetch_golden.txt", golden);
        prog_count = int'(golden[0]);
        rec_count = int'(golden[1]);
        mtvec = golden[2];

        // Program goes in while reset is held
        for (i = 0; i < prog_count; i++) begin
            @(posedge clk);
            prog_we <= 1'b1;
            prog_addr <= imem_addr_t'(i);
            prog_data <= golden[3 + i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        reseted <= 1'b0;

        for (i = 0; i < rec_count; i++) begin
            base = 3 + prog_count + i * REC_FIELDS;
            @(posedge clk);
            irq_timer <= golden[base][0];
            irq_exti <= golden[base + 1][0];
            e2f <= '{ready: golden[base + 2][0], exc_start: golden[base + 3][0],
                     flush: golden[base + 4][0], branch_taken: golden[base + 5][0],
                     branch_target: golden[base + 6]};
            @(negedge clk);
            if (golden[base + 7][0]) begin
                check_f2e(base);
            end
        end

        $display("all tests passed");
        $finish;
    end

    initial begin
        wait (rec_count != 0);
        repeat (prog_count + rec_count + 50) @(posedge clk);
        $display("timeout: the records did not complete in time");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== verilog.f ====
+incdir+include
src/fetch_pkg.sv
src/fetch_unit.sv
src/icache.sv
src/instr_mem.sv
src/fetch_top.sv
test/fetch_chk.sv
test/fetch_tb.sv
